/* logic/z3_pkg.sv */
// shared types and constants; the card window is fixed at 64 MB and the memory aliases above 1024 words
package z3_pkg;

	// config space tag, upper address half
	localparam logic [15:0] CFG_SPACE = 16'hFF00;
	// compared base bits, A31..A26
	localparam int CARD_TAG_W = 6;
	// on-card memory, word address width
	localparam int MEM_AW = 10;
	// strobe to acknowledge, in clocks
	localparam int MEM_LATENCY = 3;
	// read data settle before /DTACK
	localparam int DTACK_WAIT = 5;
	localparam int SYNC_STAGES = 2;

	// settle counter
	localparam int DLY_W = $clog2(DTACK_WAIT);
	localparam logic [DLY_W-1:0] DLY_LOAD = DLY_W'(DTACK_WAIT - 1);

	// autoconfig register index is A8..A2
	localparam int CFG_IDX_W = 7;
	// base address register, byte offset 0x44
	localparam logic [CFG_IDX_W-1:0] CFG_BASE_REG = 7'h11;

	// lane order: 31:24 on AD31..24, 23:16 on SD7..0, 15:0 on AD23..8
	typedef logic [31:0] word_t;
	typedef logic [3:0] nibble_t;

	typedef enum logic [2:0] {
		IDLE,
		MATCH,
		DATA,
		WRITE_STB,
		WRITE_WAIT,
		READ_WAIT,
		DTACK_DELAY,
		DTACK
	} zstate_t;

	// synchronized strobes, all active high
	typedef struct packed {
		logic fcs;
		logic doe;
		logic [3:0] ds;
	} bus_strobes_t;

	// latched cycle, addr is A31..A2
	typedef struct packed {
		logic [29:0] addr;
		logic read;
		logic cfg_hit;
		logic card_hit;
	} bus_cycle_t;

	// single outstanding request to card_ram
	typedef struct packed {
		logic [MEM_AW-1:0] addr;
		word_t wdata;
		logic [3:0] be;
		logic write;
	} mem_req_t;

endpackage

/* logic/z3_bus_sync.sv */
// the master must hold AD valid four clocks after /FCS falls, since the latch runs off the synchronized strobe
`timescale 1ns/10ps

module z3_bus_sync (
	input logic clk,
	input logic nIORST,
	input logic nfcs_i,
	input logic doe_i,
	input logic [3:0] nds_i,
	input logic read_i,
	input logic [1:0] fc_i,
	input logic [31:8] ad_i,
	input logic [7:2] a_i,
	input logic [z3_pkg::CARD_TAG_W-1:0] card_base_i,
	input logic cfg_en_i,
	output z3_pkg::bus_strobes_t strobes_o,
	output z3_pkg::bus_cycle_t cycle_o
);

	z3_pkg::bus_strobes_t sync_q [z3_pkg::SYNC_STAGES];
	logic fcs_prev_q;
	logic fcs_rise;
	logic fc_valid;
	logic [29:0] addr_q;
	logic read_q;
	logic cfg_hit_q;
	logic card_hit_q;

	// synchronizer chain, inverted to active high at the pins
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			for (int i = 0; i < z3_pkg::SYNC_STAGES; i++)
				sync_q[i] <= '0;
			fcs_prev_q <= 1'b0;
		end else begin
			sync_q[0] <= '{fcs: ~nfcs_i, doe: doe_i, ds: ~nds_i};
			for (int i = 1; i < z3_pkg::SYNC_STAGES; i++)
				sync_q[i] <= sync_q[i-1];
			fcs_prev_q <= strobes_o.fcs;
		end
	end

	assign strobes_o = sync_q[z3_pkg::SYNC_STAGES-1];
	assign fcs_rise = strobes_o.fcs & ~fcs_prev_q;

	// memory space codes 1 and 2 only
	assign fc_valid = fc_i[0] ^ fc_i[1];

	// address phase latch
	always_ff @(posedge clk) begin
		if (fcs_rise) begin
			addr_q <= {ad_i, a_i};
			read_q <= read_i;
		end
	end

	// space decode, dropped as soon as fcs goes away
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			cfg_hit_q <= 1'b0;
			card_hit_q <= 1'b0;
		end else if (!strobes_o.fcs) begin
			cfg_hit_q <= 1'b0;
			card_hit_q <= 1'b0;
		end else if (fcs_rise) begin
			cfg_hit_q <= fc_valid & cfg_en_i & (ad_i[31:16] == z3_pkg::CFG_SPACE);
			// card window only decoded outside autoconfig
			card_hit_q <= fc_valid & ~cfg_en_i &
				(ad_i[31 -: z3_pkg::CARD_TAG_W] == card_base_i);
		end
	end

	assign cycle_o = '{addr: addr_q, read: read_q, cfg_hit: cfg_hit_q, card_hit: card_hit_q};

endmodule

/* logic/z3_slave_fsm.sv */
// one full cycle at a time; multiple-transfer cycles and /BERR are not handled
`timescale 1ns/10ps

module z3_slave_fsm (
	input logic clk,
	input logic nIORST,
	input z3_pkg::bus_strobes_t strobes_i,
	input z3_pkg::bus_cycle_t cycle_i,
	input logic nfcs_i,
	input logic [31:8] ad_i,
	input logic [7:0] sd_i,
	input z3_pkg::nibble_t cfg_rdata_i,
	input z3_pkg::word_t mem_rdata_i,
	input logic mem_ack_i,
	output z3_pkg::mem_req_t mem_req_o,
	output logic mem_stb_o,
	output logic cfg_wr_o,
	output z3_pkg::word_t cfg_wdata_o,
	output z3_pkg::word_t rdata_o,
	output logic nslaven_o,
	output logic ndtack_o
);

	z3_pkg::zstate_t state_q;
	z3_pkg::zstate_t state_d;
	logic [z3_pkg::DLY_W-1:0] dly_q;
	z3_pkg::word_t wdata_q;
	logic [3:0] be_q;
	logic hit;
	z3_pkg::word_t bus_word;

	assign hit = cycle_i.cfg_hit | cycle_i.card_hit;
	// data phase lanes back into word order
	assign bus_word = {ad_i[31:24], sd_i, ad_i[23:8]};

	always_comb begin
		state_d = state_q;
		// negated fcs ends any cycle
		if (!strobes_i.fcs) begin
			state_d = z3_pkg::IDLE;
		end else begin
			case (state_q)
				z3_pkg::IDLE:
					if (hit)
						state_d = z3_pkg::MATCH;
				// wait for the master to open data time
				z3_pkg::MATCH:
					if (strobes_i.doe)
						state_d = z3_pkg::DATA;
				z3_pkg::DATA:
					if (cycle_i.read) begin
						if (cycle_i.cfg_hit)
							state_d = z3_pkg::DTACK_DELAY;
						else
							state_d = z3_pkg::READ_WAIT;
					end else if (|strobes_i.ds) begin
						state_d = z3_pkg::WRITE_STB;
					end
				z3_pkg::WRITE_STB:
					state_d = z3_pkg::WRITE_WAIT;
				// cfg writes need no ack
				z3_pkg::WRITE_WAIT:
					if (cycle_i.cfg_hit || mem_ack_i)
						state_d = z3_pkg::DTACK;
				z3_pkg::READ_WAIT:
					if (mem_ack_i)
						state_d = z3_pkg::DTACK_DELAY;
				z3_pkg::DTACK_DELAY:
					if (dly_q == '0)
						state_d = z3_pkg::DTACK;
				// held here until the master lets go of fcs
				z3_pkg::DTACK:
					state_d = z3_pkg::DTACK;
				default:
					state_d = z3_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			state_q <= z3_pkg::IDLE;
			dly_q <= '0;
			mem_stb_o <= 1'b0;
			cfg_wr_o <= 1'b0;
		end else begin
			state_q <= state_d;
			// settle counter, loaded on entry
			if (state_d == z3_pkg::DTACK_DELAY && state_q != z3_pkg::DTACK_DELAY)
				dly_q <= z3_pkg::DLY_LOAD;
			else if (dly_q != '0)
				dly_q <= dly_q - 1'b1;
			// card read starts with data time, card write two clocks after capture
			mem_stb_o <= cycle_i.card_hit &
				((state_q == z3_pkg::MATCH && state_d == z3_pkg::DATA && cycle_i.read) ||
				(state_q == z3_pkg::WRITE_STB));
			cfg_wr_o <= cycle_i.cfg_hit & (state_q == z3_pkg::WRITE_STB);
		end
	end

	// write data and byte lanes on the first data strobe
	always_ff @(posedge clk) begin
		if (state_q == z3_pkg::DATA && !cycle_i.read && (|strobes_i.ds)) begin
			wdata_q <= bus_word;
			be_q <= strobes_i.ds;
		end
	end

	// read word, nibble on top with ones below for config space
	always_ff @(posedge clk) begin
		if (state_q == z3_pkg::DATA && cycle_i.read && cycle_i.cfg_hit)
			rdata_o <= {cfg_rdata_i, 28'hFFF_FFFF};
		else if (state_q == z3_pkg::READ_WAIT && mem_ack_i)
			rdata_o <= mem_rdata_i;
	end

	assign mem_req_o.addr = cycle_i.addr[z3_pkg::MEM_AW-1:0];
	assign mem_req_o.wdata = wdata_q;
	assign mem_req_o.be = be_q;
	assign mem_req_o.write = ~cycle_i.read;
	assign cfg_wdata_o = wdata_q;

	// both lines follow raw /FCS up at the end of the cycle
	assign nslaven_o = nfcs_i | (state_q == z3_pkg::IDLE);
	assign ndtack_o = nfcs_i | nslaven_o | (state_q != z3_pkg::DTACK);

endmodule

/* logic/z3_autoconfig.sv */
// only the base register at offset 0x44 is writable; no shut-up and no second config pass until reset
`timescale 1ns/10ps

module z3_autoconfig (
	input logic clk,
	input logic nIORST,
	input z3_pkg::bus_cycle_t cycle_i,
	input logic ncfgin_i,
	input logic cfg_wr_i,
	input z3_pkg::word_t cfg_wdata_i,
	output z3_pkg::nibble_t cfg_rdata_o,
	output logic [z3_pkg::CARD_TAG_W-1:0] card_base_o,
	output logic cfg_en_o,
	output logic ncfgout_o
);

	logic [z3_pkg::CFG_IDX_W-1:0] reg_idx;
	logic configured_q;
	logic base_wr;

	// register index is A8..A2 of the latched address
	assign reg_idx = cycle_i.addr[z3_pkg::CFG_IDX_W-1:0];

	// nibble table
	always_comb begin
		case (reg_idx)
			// board type
			7'h00:
				cfg_rdata_o = 4'hA;
			// size field
			7'h01:
				cfg_rdata_o = 4'h7;
			// product number, both nibbles
			7'h02:
				cfg_rdata_o = 4'hE;
			7'h03:
				cfg_rdata_o = 4'h9;
			// unused registers read all ones
			default:
				cfg_rdata_o = 4'hF;
		endcase
	end

	assign base_wr = cfg_wr_i & ~configured_q & (reg_idx == z3_pkg::CFG_BASE_REG);

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			configured_q <= 1'b0;
			card_base_o <= '0;
		end else if (base_wr) begin
			configured_q <= 1'b1;
			// A31..A26 of the base travel on word bits 15:10
			card_base_o <= cfg_wdata_i[15:10];
		end
	end

	// answer config space only while first in line
	assign cfg_en_o = ~configured_q & ~ncfgin_i;
	// pass the chain on once configured
	assign ncfgout_o = ~configured_q;

endmodule

/* logic/card_ram.sv */
// stand-in for the SDRAM controller; one request at a time, addresses alias every 1024 words
`timescale 1ns/10ps

module card_ram (
	input logic clk,
	input logic nIORST,
	input z3_pkg::mem_req_t req_i,
	input logic stb_i,
	output z3_pkg::word_t rdata_o,
	output logic ack_o
);

	z3_pkg::word_t mem [2**z3_pkg::MEM_AW];
	logic [z3_pkg::MEM_LATENCY-1:0] ack_pipe_q;

	// byte-enabled write
	always_ff @(posedge clk) begin
		if (stb_i && req_i.write) begin
			for (int b = 0; b < 4; b++) begin
				if (req_i.be[b])
					mem[req_i.addr][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
			end
		end
	end

	// read word held until the ack
	always_ff @(posedge clk) begin
		if (stb_i && !req_i.write)
			rdata_o <= mem[req_i.addr];
	end

	// ack delay line
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST)
			ack_pipe_q <= '0;
		else
			ack_pipe_q <= {ack_pipe_q[z3_pkg::MEM_LATENCY-2:0], stb_i};
	end

	assign ack_o = ack_pipe_q[z3_pkg::MEM_LATENCY-1];

endmodule

/* logic/z3_card.sv */
// split AD/SD buses with one output enable; the board must combine them into its tri-state pads
`timescale 1ns/10ps

module z3_card (
	input logic clk,
	input logic nIORST,
	input logic nfcs_i,
	input logic doe_i,
	input logic read_i,
	input logic [3:0] nds_i,
	input logic [1:0] fc_i,
	input logic [31:8] ad_i,
	input logic [7:2] a_i,
	input logic [7:0] sd_i,
	input logic ncfgin_i,
	output logic [31:8] ad_o,
	output logic [7:0] sd_o,
	output logic data_oe_o,
	output logic nslaven_o,
	output logic ndtack_o,
	output logic ncfgout_o
);

	z3_pkg::bus_strobes_t strobes;
	z3_pkg::bus_cycle_t cycle;
	logic [z3_pkg::CARD_TAG_W-1:0] card_base;
	logic cfg_en;
	z3_pkg::nibble_t cfg_rdata;
	logic cfg_wr;
	z3_pkg::word_t cfg_wdata;
	z3_pkg::mem_req_t mem_req;
	logic mem_stb;
	z3_pkg::word_t mem_rdata;
	logic mem_ack;
	z3_pkg::word_t rdata;

	z3_bus_sync u_sync (
		.clk(clk), .nIORST(nIORST),
		.nfcs_i(nfcs_i), .doe_i(doe_i), .nds_i(nds_i), .read_i(read_i),
		.fc_i(fc_i), .ad_i(ad_i), .a_i(a_i),
		.card_base_i(card_base), .cfg_en_i(cfg_en),
		.strobes_o(strobes), .cycle_o(cycle)
	);

	z3_slave_fsm u_fsm (
		.clk(clk), .nIORST(nIORST),
		.strobes_i(strobes), .cycle_i(cycle), .nfcs_i(nfcs_i),
		.ad_i(ad_i), .sd_i(sd_i), .cfg_rdata_i(cfg_rdata),
		.mem_rdata_i(mem_rdata), .mem_ack_i(mem_ack),
		.mem_req_o(mem_req), .mem_stb_o(mem_stb),
		.cfg_wr_o(cfg_wr), .cfg_wdata_o(cfg_wdata), .rdata_o(rdata),
		.nslaven_o(nslaven_o), .ndtack_o(ndtack_o)
	);

	z3_autoconfig u_acfg (
		.clk(clk), .nIORST(nIORST),
		.cycle_i(cycle), .ncfgin_i(ncfgin_i),
		.cfg_wr_i(cfg_wr), .cfg_wdata_i(cfg_wdata),
		.cfg_rdata_o(cfg_rdata), .card_base_o(card_base),
		.cfg_en_o(cfg_en), .ncfgout_o(ncfgout_o)
	);

	card_ram u_ram (
		.clk(clk), .nIORST(nIORST),
		.req_i(mem_req), .stb_i(mem_stb),
		.rdata_o(mem_rdata), .ack_o(mem_ack)
	);

	// read word back out in lane order
	assign ad_o = {rdata[31:24], rdata[15:0]};
	assign sd_o = rdata[23:16];

	// drive only in read data time of our own cycle
	assign data_oe_o = ~nfcs_i & ~nslaven_o & doe_i & read_i;

endmodule

/* dv/z3_card_assertions.sv */
// watches the top-level pins only and the rules are off while nIORST is low
`timescale 1ns/10ps

module z3_card_assertions (
	input logic clk,
	input logic nIORST,
	input logic nfcs_i,
	input logic read_i,
	input logic nslaven_i,
	input logic ndtack_i,
	input logic data_oe_i,
	input logic ncfgout_i
);

	// failed rules so far
	int unsigned fail_cnt = 0;

	// acknowledge only after /SLAVEN has been low for a clock
	dtack_needs_slaven: assert property (@(posedge clk) disable iff (!nIORST)
		!ndtack_i |-> (!nslaven_i && $past(!nslaven_i)))
	else begin
		fail_cnt++;
		$error("/DTACK low without /SLAVEN low ahead of it");
	end

	// drive AD/SD only in a read with /FCS low
	oe_in_read_only: assert property (@(posedge clk) disable iff (!nIORST)
		data_oe_i |-> (!nfcs_i && read_i))
	else begin
		fail_cnt++;
		$error("data output enable outside read data time");
	end

	// configured until reset
	cfgout_sticky: assert property (@(posedge clk) disable iff (!nIORST)
		!ncfgout_i |=> !ncfgout_i)
	else begin
		fail_cnt++;
		$error("/CFGOUT went high again after configuration");
	end

endmodule

bind z3_card z3_card_assertions u_asrt (
	.clk(clk), .nIORST(nIORST), .nfcs_i(nfcs_i), .read_i(read_i),
	.nslaven_i(nslaven_o), .ndtack_i(ndtack_o),
	.data_oe_i(data_oe_o), .ncfgout_i(ncfgout_o)
);

/* dv/tb_z3_card.sv */
// run from the project root so the tests file is found; the card is first in the config chain
`timescale 1ns/10ps

module tb_z3_card;

	logic clk;
	logic nIORST;
	logic nfcs_i;
	logic doe_i;
	logic read_i;
	logic [3:0] nds_i;
	logic [1:0] fc_i;
	logic [31:8] ad_i;
	logic [7:2] a_i;
	logic [7:0] sd_i;
	logic ncfgin_i;
	logic [31:8] ad_o;
	logic [7:0] sd_o;
	logic data_oe_o;
	logic nslaven_o;
	logic ndtack_o;
	logic ncfgout_o;

	z3_card uut (
		.clk(clk), .nIORST(nIORST),
		.nfcs_i(nfcs_i), .doe_i(doe_i), .read_i(read_i), .nds_i(nds_i), .fc_i(fc_i),
		.ad_i(ad_i), .a_i(a_i), .sd_i(sd_i), .ncfgin_i(ncfgin_i),
		.ad_o(ad_o), .sd_o(sd_o), .data_oe_o(data_oe_o),
		.nslaven_o(nslaven_o), .ndtack_o(ndtack_o), .ncfgout_o(ncfgout_o)
	);

	// 8 ns clock
	always #4 clk = ~clk;

	task automatic fail_now(input string why);
		$display("ERROR: %s", why);
		$display("Done: errors found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input z3_pkg::word_t exp,
			input z3_pkg::word_t act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			fail_now("read word differs from the expected word");
		end
	endtask

	task automatic check_nibble(input string name, input z3_pkg::nibble_t exp,
			input z3_pkg::nibble_t act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			fail_now("autoconfig nibble differs from the table");
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %b actual %b", name, exp, act);
			fail_now("control line at the wrong level");
		end
	endtask

	// assertion failures in the bound checker
	always @(posedge clk) begin
		if (uut.u_asrt.fail_cnt != 0)
			fail_now("a bus protocol assertion failed");
	end

	// one full master cycle with flags for what the slave did
	task automatic run_cycle(input logic [1:0] fc, input z3_pkg::word_t addr,
			input z3_pkg::word_t data, input logic [3:0] nds, input logic rd,
			output logic seen_slaven, output logic seen_dtack, output logic seen_oe,
			output z3_pkg::word_t rdata);
		int n;
		seen_slaven = 1'b0;
		seen_dtack = 1'b0;
		seen_oe = 1'b0;
		rdata = '0;
		// address and FC set up ahead of /FCS
		@(posedge clk);
		fc_i <= fc;
		ad_i <= addr[31:8];
		a_i <= addr[7:2];
		read_i <= rd;
		@(posedge clk);
		nfcs_i <= 1'b0;
		// address held four clocks for the synchronized latch
		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
			if (!nslaven_o)
				seen_slaven = 1'b1;
		end
		// data time with the write word in lane order
		doe_i <= 1'b1;
		if (!rd) begin
			ad_i <= {data[31:24], data[15:0]};
			sd_i <= data[23:16];
		end
		@(posedge clk);
		nds_i <= nds;
		// wait at most 40 clocks for /DTACK
		n = 0;
		while (ndtack_o && n < 40) begin
			@(posedge clk);
			// /SLAVEN has to lead /DTACK
			if (!nslaven_o && ndtack_o)
				seen_slaven = 1'b1;
			n++;
		end
		if (!ndtack_o) begin
			seen_dtack = 1'b1;
			seen_oe = data_oe_o;
			rdata = {ad_o[31:24], sd_o, ad_o[23:8]};
		end
		// end of cycle
		nfcs_i <= 1'b1;
		doe_i <= 1'b0;
		nds_i <= 4'hF;
		n = 0;
		@(posedge clk);
		while (!nslaven_o && n < 40) begin
			@(posedge clk);
			n++;
		end
		if (!nslaven_o || !ndtack_o)
			fail_now("/SLAVEN or /DTACK stayed low after /FCS was negated");
		// let the synchronizers drain
		repeat (3) @(posedge clk);
	endtask

	task automatic run_test(input string name, input string op, input logic [1:0] fc,
			input z3_pkg::word_t addr, input z3_pkg::word_t data, input logic [3:0] nds,
			input z3_pkg::word_t exp_w);
		logic rd;
		logic seen_slaven;
		logic seen_dtack;
		logic seen_oe;
		z3_pkg::word_t got;
		if (op != "cfg_read" && op != "cfg_write" && op != "mem_read" &&
				op != "mem_write" && op != "no_resp")
			fail_now({"unknown operation in test ", name});
		rd = (op == "cfg_read" || op == "mem_read" || op == "no_resp");
		run_cycle(fc, addr, data, nds, rd, seen_slaven, seen_dtack, seen_oe, got);
		if (op == "no_resp") begin
			check_level({name, " slaven_seen"}, 1'b0, seen_slaven);
			check_level({name, " dtack_seen"}, 1'b0, seen_dtack);
		end else begin
			if (!seen_dtack)
				fail_now({name, ": timeout, no /DTACK within 40 clocks"});
			check_level({name, " slaven_seen"}, 1'b1, seen_slaven);
			check_level({name, " data_oe"}, rd, seen_oe);
			if (op == "cfg_read") begin
				check_nibble(name, exp_w[31:28], got[31:28]);
				check_word(name, exp_w, got);
			end else if (op == "mem_read") begin
				check_word(name, exp_w, got);
			end else if (op == "cfg_write") begin
				check_level({name, " ncfgout"}, exp_w[0], ncfgout_o);
			end
		end
	endtask

	initial begin
		string line;
		string name;
		string op;
		int fd;
		int cnt;
		int ntests;
		logic [1:0] fc;
		z3_pkg::word_t addr;
		z3_pkg::word_t data;
		logic [3:0] nds;
		z3_pkg::word_t exp_w;
		clk = 1'b0;
		nIORST = 1'b0;
		nfcs_i = 1'b1;
		doe_i = 1'b0;
		read_i = 1'b0;
		nds_i = 4'hF;
		fc_i = 2'b00;
		ad_i = '0;
		a_i = '0;
		sd_i = '0;
		// first in the chain
		ncfgin_i = 1'b0;
		ntests = 0;
		repeat (4) @(posedge clk);
		nIORST <= 1'b1;
		repeat (2) @(posedge clk);
		// idle levels out of reset
		check_level("reset nslaven", 1'b1, nslaven_o);
		check_level("reset ndtack", 1'b1, ndtack_o);
		check_level("reset ncfgout", 1'b1, ncfgout_o);
		check_level("reset data_oe", 1'b0, data_oe_o);
		fd = $fopen("dv/z3_tests.txt", "r");
		if (fd == 0)
			fail_now("cannot open dv/z3_tests.txt");
		while (!$feof(fd)) begin
			line = "";
			cnt = $fgets(line, fd);
			// skip blank and comment lines
			if (cnt == 0 || line.len() < 2 || line.getc(0) == "#")
				continue;
			cnt = $sscanf(line, "%s %s %h %h %h %h %h", name, op, fc, addr, data, nds, exp_w);
			if (cnt != 7)
				fail_now({"malformed line in the tests file: ", line});
			run_test(name, op, fc, addr, data, nds, exp_w);
			ntests++;
		end
		$fclose(fd);
		if (ntests == 0)
			fail_now("the tests file holds no tests");
		if (uut.u_asrt.fail_cnt == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			fail_now("a bus protocol assertion failed");
		end
	end

endmodule

/* dv/z3_tests.txt */
# columns: name op fc addr data nds expected (all numbers hex)
# nds is the active-low /DS3..0 value; expected is the read word, or the /CFGOUT level for cfg_write
# autoconfig table, nibble on top and ones below
cfg_rd_idx0 cfg_read 1 FF000000 00000000 0 AFFFFFFF
cfg_rd_idx1 cfg_read 1 FF000004 00000000 0 7FFFFFFF
cfg_rd_idx2 cfg_read 1 FF000008 00000000 0 EFFFFFFF
cfg_rd_idx3 cfg_read 1 FF00000C 00000000 0 9FFFFFFF
cfg_rd_idx4 cfg_read 1 FF000010 00000000 0 FFFFFFFF
cfg_rd_idx0_fc2 cfg_read 2 FF000000 00000000 0 AFFFFFFF
cfg_rd_unused cfg_read 1 FF000100 00000000 0 FFFFFFFF
# base 0x40000000, A31..A26 on bits 15:10
cfg_wr_base cfg_write 1 FF000044 00004000 0 00000000
cfg_rd_after_config no_resp 1 FF000000 00000000 0 00000000
cfg_rd_idx1_after_config no_resp 1 FF000004 00000000 0 00000000
# full-word writes into the card window
mem_wr_w0 mem_write 1 40000000 11223344 0 00000000
mem_wr_w1 mem_write 1 40000004 55667788 0 00000000
mem_wr_w1023 mem_write 2 40000FFC A5A55A5A 0 00000000
mem_wr_w4 mem_write 1 40000010 DEADBEEF 0 00000000
# read back out of order and through aliases
mem_rd_w1023 mem_read 1 40000FFC 00000000 0 A5A55A5A
mem_rd_w0 mem_read 2 40000000 00000000 0 11223344
mem_rd_w4_alias mem_read 1 40001010 00000000 0 DEADBEEF
mem_rd_w1_alias mem_read 1 43FFF004 00000000 0 55667788
mem_rd_w0_alias mem_read 1 40400000 00000000 0 11223344
mem_wr_w0_alias mem_write 1 40001000 CAFEF00D 0 00000000
mem_rd_w0_after_alias mem_read 1 40000000 00000000 0 CAFEF00D
# byte lanes, DS1 and DS0 only then DS3 and DS2 only
mem_wr_prefill_lo mem_write 1 40000020 FFFFFFFF 0 00000000
mem_wr_ds10 mem_write 1 40000020 00001234 C 00000000
mem_rd_merged_lo mem_read 1 40000020 00000000 0 FFFF1234
mem_wr_prefill_hi mem_write 1 40000024 12345678 0 00000000
mem_wr_ds32 mem_write 1 40000024 AABB0000 3 00000000
mem_rd_merged_hi mem_read 1 40000024 00000000 0 AABB5678
# outside the window or bad FC
no_resp_outside_lo no_resp 1 3C000000 00000000 0 00000000
no_resp_outside_hi no_resp 1 44000000 00000000 0 00000000
no_resp_fc0 no_resp 0 40000000 00000000 0 00000000
no_resp_fc3 no_resp 3 40000000 00000000 0 00000000
mem_rd_w0_final mem_read 1 40000000 00000000 0 CAFEF00D

/* tb.f */
logic/z3_pkg.sv
logic/z3_bus_sync.sv
logic/z3_slave_fsm.sv
logic/z3_autoconfig.sv
logic/card_ram.sv
logic/z3_card.sv
dv/z3_card_assertions.sv
dv/tb_z3_card.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_z3_card -f tb.f
out=$(./obj_dir/Vtb_z3_card) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'Done: no errors'; then
	exit 0
fi
exit 1
